// File: all.f
hdl/lsu_pkg.sv
hdl/lsu_ctrl.sv
hdl/lsu_strobe_gen.sv
hdl/lsu_load_align.sv
hdl/lsu_l1d.sv
hdl/lsu_top.sv
bench/wb_mem_model.sv
bench/lsu_tb.sv

// File: bench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int DONE_TIMEOUT = 40;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic [31:0] req_addr;
  mem_op_e     req_op;
  logic [31:0] req_wdata;
  logic        done;
  logic [31:0] rdata;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [31:0] mem_cycles;
  logic [1:0]  wait_cycles;

  // expected response of the access in flight
  logic        exp_load;
  logic        exp_hit;
  logic        exp_we;
  logic [31:0] exp_rdata;
  logic [31:0] exp_adr;
  logic [3:0]  exp_sel;
  logic [31:0] exp_dat;
  logic [31:0] exp_cycles;
  logic [31:0] lane_mask;

  // reference copies of memory and cache state
  logic [31:0] shadow [1024];
  logic [3:0]  line_valid;
  logic [27:0] line_tag [4];

  logic [31:0] rand_state = 32'h304c;
  logic        past_first_edge = 1'b0;
  int          data_errs = 0;
  int          bus_errs = 0;
  int          cache_errs = 0;
  int          timeouts = 0;

  mem_op_e     ops [8] = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
  logic [31:0] bases [6] = '{32'h8000_0000, 32'h8000_0100, 32'h8000_0200,
                             32'h4000_0300, 32'h8040_0500, 32'hA000_0600};

  lsu_top dut_i (
    .clk         (clk),
    .reset_i     (reset),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .req_op_i    (req_op),
    .req_wdata_i (req_wdata),
    .done_o      (done),
    .rdata_o     (rdata),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_sel_o    (wb_sel),
    .wb_dat_o    (wb_dat_w),
    .wb_dat_i    (wb_dat_r),
    .wb_ack_i    (wb_ack)
  );

  wb_mem_model mem_i (
    .clk           (clk),
    .reset_i       (reset),
    .cyc_i         (wb_cyc),
    .stb_i         (wb_stb),
    .we_i          (wb_we),
    .adr_i         (wb_adr),
    .sel_i         (wb_sel),
    .dat_i         (wb_dat_w),
    .wait_cycles_i (wait_cycles),
    .dat_o         (wb_dat_r),
    .ack_o         (wb_ack),
    .cycles_o      (mem_cycles)
  );

  assign lane_mask = {{8{exp_sel[3]}}, {8{exp_sel[2]}}, {8{exp_sel[1]}}, {8{exp_sel[0]}}};

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    past_first_edge <= 1'b1;
  end

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic in_cache_window(input logic [31:0] addr);
    return ((addr >= CACHE_WIN0_LO) && (addr < CACHE_WIN0_HI)) ||
           ((addr >= CACHE_WIN1_LO) && (addr < CACHE_WIN1_HI));
  endfunction

  // byte or halfword picked out of the word, then extended
  function automatic logic [31:0] expected_load(input mem_op_e op, input logic [31:0] word,
                                                input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = word[16*off[1] +: 16];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'h00_0000, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'h0000, h};
      default: return word;
    endcase
  endfunction

  task automatic run_access(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
    logic [9:0]  widx;
    logic [1:0]  off;
    logic [1:0]  idx;
    logic [27:0] tag;
    logic        store;
    logic        line_hit;
    logic [31:0] r;
    int          waited;
    if (timeouts != 0) begin
      return;
    end
    @(negedge clk);
    widx     = addr[11:2];
    off      = addr[1:0];
    idx      = addr[3:2];
    tag      = addr[31:4];
    store    = (op == SB) || (op == SH) || (op == SW);
    line_hit = in_cache_window(addr) && line_valid[idx] && (line_tag[idx] == tag);
    exp_load  = !store;
    exp_we    = store;
    exp_hit   = !store && line_hit;
    exp_rdata = expected_load(op, shadow[widx], off);
    exp_adr   = addr & 32'hffff_fffc;
    case (op)
      SB: begin
        case (off)
          2'd0:    exp_sel = 4'b0001;
          2'd1:    exp_sel = 4'b0010;
          2'd2:    exp_sel = 4'b0100;
          default: exp_sel = 4'b1000;
        endcase
        exp_dat = {24'h00_0000, wdata[7:0]} << (8 * off);
      end
      SH: begin
        exp_sel = off[1] ? 4'b1100 : 4'b0011;
        exp_dat = {16'h0000, wdata[15:0]} << (16 * off[1]);
      end
      default: begin
        exp_sel = 4'b1111;
        exp_dat = wdata;
      end
    endcase
    exp_cycles = mem_cycles + (exp_hit ? 32'd0 : 32'd1);
    r = next_random();
    wait_cycles = r[31:30];
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    req_valid = 1'b1;
    waited = 0;
    while (!done && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      timeouts++;
      $display("timeout at %0t: no done_o for %s at %h", $time, op.name(), addr);
      req_valid = 1'b0;
    end else begin
      // fields stay stable through the done cycle
      @(negedge clk);
      req_valid = 1'b0;
      if (store) begin
        for (int b = 0; b < 4; b++) begin
          if (exp_sel[b]) begin
            shadow[widx][8*b +: 8] = exp_dat[8*b +: 8];
          end
        end
        if (line_hit) begin
          line_valid[idx] = 1'b0;
        end
      end else if (in_cache_window(addr)) begin
        line_valid[idx] = 1'b1;
        line_tag[idx]   = tag;
      end
    end
  endtask

  load_data_chk: assert property (@(posedge clk) disable iff (reset)
      done && exp_load |-> rdata == exp_rdata)
    else begin
      data_errs++;
      $display("CHECK FAILED at %0t: rdata_o expected %h got %h",
               $time, $sampled(exp_rdata), $sampled(rdata));
    end

  adr_chk: assert property (@(posedge clk) disable iff (reset)
      wb_cyc |-> wb_adr == exp_adr)
    else begin
      bus_errs++;
      $display("CHECK FAILED at %0t: wb_adr_o expected %h got %h",
               $time, $sampled(exp_adr), $sampled(wb_adr));
    end

  store_sel_chk: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && wb_we |-> wb_sel == exp_sel)
    else begin
      bus_errs++;
      $display("CHECK FAILED at %0t: wb_sel_o expected %h got %h",
               $time, $sampled(exp_sel), $sampled(wb_sel));
    end

  store_dat_chk: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && wb_we |-> (wb_dat_w & lane_mask) == (exp_dat & lane_mask))
    else begin
      bus_errs++;
      $display("CHECK FAILED at %0t: wb_dat_o expected %h got %h", $time,
               $sampled(exp_dat & lane_mask), $sampled(wb_dat_w & lane_mask));
    end

  we_chk: assert property (@(posedge clk) disable iff (reset)
      wb_cyc |-> wb_we == exp_we)
    else begin
      bus_errs++;
      $display("CHECK FAILED at %0t: wb_we_o expected %b got %b",
               $time, $sampled(exp_we), $sampled(wb_we));
    end

  // hits stay off the bus, everything else costs one bus cycle
  bus_count_chk: assert property (@(posedge clk) disable iff (reset)
      done |-> mem_cycles == exp_cycles)
    else begin
      cache_errs++;
      $display("CHECK FAILED at %0t: bus cycle count expected %0d got %0d",
               $time, $sampled(exp_cycles), $sampled(mem_cycles));
    end

  hit_latency_chk: assert property (@(posedge clk) disable iff (reset)
      $rose(req_valid) && exp_hit |-> ##2 done)
    else begin
      cache_errs++;
      $display("cache hit at %0t did not complete two cycles after the request", $time);
    end

  done_pulse_chk: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      bus_errs++;
      $display("done_o stayed high for more than one cycle at %0t", $time);
    end

  stb_chk: assert property (@(posedge clk) disable iff (reset) wb_stb == wb_cyc)
    else begin
      bus_errs++;
      $display("CHECK FAILED at %0t: wb_stb_o expected %b got %b",
               $time, $sampled(wb_cyc), $sampled(wb_stb));
    end

  hold_chk: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_sel) && $stable(wb_we))
    else begin
      bus_errs++;
      $display("bus cycle dropped or changed before ack at %0t", $time);
    end

  release_chk: assert property (@(posedge clk) disable iff (reset) wb_cyc && wb_ack |=> !wb_cyc)
    else begin
      bus_errs++;
      $display("wb_cyc_o still high the cycle after ack at %0t", $time);
    end

  reset_chk: assert property (@(posedge clk)
      reset && past_first_edge |-> !wb_cyc && !wb_stb && !done)
    else begin
      bus_errs++;
      $display("cyc, stb or done_o high during reset at %0t", $time);
    end

  initial begin
    logic [31:0] r;
    logic [31:0] base;
    logic [1:0]  off;
    mem_op_e     op;
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_op      = LW;
    req_wdata   = '0;
    wait_cycles = '0;
    exp_load    = 1'b0;
    exp_hit     = 1'b0;
    exp_we      = 1'b0;
    exp_rdata   = '0;
    exp_adr     = '0;
    exp_sel     = '0;
    exp_dat     = '0;
    exp_cycles  = '0;
    line_valid  = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = mem_i.mem[i];
    end

    // fill, hits, store invalidate and sign handling on one line
    run_access(LW, 32'h8000_0004, 32'h0);
    run_access(LW, 32'h8000_0004, 32'h0);
    run_access(LB, 32'h8000_0005, 32'h0);
    run_access(LBU, 32'h8000_0007, 32'h0);
    run_access(SH, 32'h8000_0006, 32'h0000_8001);
    run_access(LH, 32'h8000_0006, 32'h0);
    run_access(LHU, 32'h8000_0006, 32'h0);
    run_access(SB, 32'h8000_0005, 32'h0000_00f0);
    run_access(LB, 32'h8000_0005, 32'h0);
    run_access(LBU, 32'h8000_0005, 32'h0);
    // same index, other tag
    run_access(LW, 32'h8000_0104, 32'h0);
    run_access(LW, 32'h8000_0004, 32'h0);
    // uncached twice, then window 1
    run_access(LW, 32'h4000_0304, 32'h0);
    run_access(LW, 32'h4000_0304, 32'h0);
    run_access(LW, 32'hA000_0608, 32'h0);
    run_access(LW, 32'hA000_0608, 32'h0);
    run_access(SW, 32'hA000_0608, 32'hc0de_8765);
    run_access(LW, 32'hA000_0608, 32'h0);

    for (int n = 0; n < 300; n++) begin
      r    = next_random();
      base = bases[(r >> 12) % 6];
      op   = ops[r[26:24]];
      case (op)
        LB, LBU, SB: off = r[17:16];
        LH, LHU, SH: off = {r[17], 1'b0};
        default:     off = 2'b00;
      endcase
      run_access(op, base + {r[21:20], 2'b00} + off, next_random());
    end

    for (int i = 0; i < 1024; i++) begin
      assert (mem_i.mem[i] == shadow[i])
      else begin
        data_errs++;
        $display("CHECK FAILED at %0t: mem[%0d] expected %h got %h",
                 $time, i, shadow[i], mem_i.mem[i]);
      end
    end

    $display("errors: data %0d, bus %0d, cache %0d, timeouts %0d",
             data_errs, bus_errs, cache_errs, timeouts);
    if (data_errs + bus_errs + cache_errs + timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: bench/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  input  logic [1:0]  wait_cycles_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic [31:0] cycles_o
);

  // 4 KiB image, upper address bits fold onto it
  logic [31:0] mem [1024];
  logic [1:0]  wait_cnt;
  logic        busy;
  logic [9:0]  widx;

  assign widx = adr_i[11:2];

  // every bit of the word index feeds the pattern
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = ((i + 1) * 32'h9e37_79b1) ^ 32'ha5c3_0f96;
    end
  end

  always @(posedge clk) begin
    if (reset_i) begin
      ack_o    <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= '0;
      cycles_o <= '0;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        // first cycle of a new bus cycle
        if (!busy) begin
          cycles_o <= cycles_o + 1;
        end
        busy <= 1'b1;
        if (wait_cnt == wait_cycles_i) begin
          ack_o    <= 1'b1;
          busy     <= 1'b0;
          wait_cnt <= '0;
          if (we_i) begin
            for (int b = 0; b < 4; b++) begin
              if (sel_i[b]) begin
                mem[widx][8*b +: 8] <= dat_i[8*b +: 8];
              end
            end
          end else begin
            dat_o <= mem[widx];
          end
        end else begin
          wait_cnt <= wait_cnt + 2'd1;
        end
      end
    end
  end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                       clk,
  input  logic                       reset_i,
  // execute side
  input  logic                       req_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0] req_addr_i,
  input  lsu_pkg::mem_op_e           req_op_i,
  input  logic [lsu_pkg::DATA_W-1:0] req_wdata_i,
  output logic                       done_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  // wishbone classic master
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [lsu_pkg::ADDR_W-1:0] wb_adr_o,
  output logic [lsu_pkg::SEL_W-1:0]  wb_sel_o,
  output logic [lsu_pkg::DATA_W-1:0] wb_dat_o,
  input  logic [lsu_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                       wb_ack_i
);

  import lsu_pkg::*;

  logic              req_is_store;
  logic              hit;
  logic [DATA_W-1:0] hit_data;
  logic              fill_en;
  logic              inval_en;
  logic              data_sel;
  logic [DATA_W-1:0] bus_word_q;
  logic [DATA_W-1:0] align_word;

  assign req_is_store = is_store_op(req_op_i);

  // bus is word addressed, lanes come from sel
  assign wb_adr_o = {req_addr_i[ADDR_W-1:2], 2'b00};

  lsu_ctrl ctrl_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .req_valid_i    (req_valid_i),
    .req_is_store_i (req_is_store),
    .hit_i          (hit),
    .wb_ack_i       (wb_ack_i),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .fill_en_o      (fill_en),
    .inval_en_o     (inval_en),
    .done_o         (done_o),
    .data_sel_o     (data_sel)
  );

  lsu_strobe_gen strobe_i (
    .op_i      (req_op_i),
    .addr_lo_i (req_addr_i[1:0]),
    .wdata_i   (req_wdata_i),
    .sel_o     (wb_sel_o),
    .wdata_o   (wb_dat_o)
  );

  lsu_l1d l1d_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .addr_i      (req_addr_i),
    .fill_en_i   (fill_en),
    .inval_en_i  (inval_en),
    .fill_data_i (wb_dat_i),
    .hit_o       (hit),
    .hit_data_o  (hit_data)
  );

  // hold the acked read word for the done cycle
  always_ff @(posedge clk) begin
    if (fill_en) begin
      bus_word_q <= wb_dat_i;
    end
  end

  assign align_word = data_sel ? bus_word_q : hit_data;

  lsu_load_align align_i (
    .op_i      (req_op_i),
    .addr_lo_i (req_addr_i[1:0]),
    .word_i    (align_word),
    .rdata_o   (rdata_o)
  );

endmodule

// File: hdl/lsu_l1d.sv
`timescale 1ns/1ps

module lsu_l1d (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
  input  logic                       fill_en_i,
  input  logic                       inval_en_i,
  input  logic [lsu_pkg::DATA_W-1:0] fill_data_i,
  output logic                       hit_o,
  output logic [lsu_pkg::DATA_W-1:0] hit_data_o
);

  import lsu_pkg::*;

  logic [DATA_W-1:0]    data_q  [L1D_LINES];
  logic [L1D_TAG_W-1:0] tag_q   [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;

  logic [L1D_IDX_W-1:0] idx;
  logic [L1D_TAG_W-1:0] tag;
  logic                 in_win0;
  logic                 in_win1;
  logic                 cacheable;

  // word offset bits [1:0] are not part of the lookup
  assign idx = addr_i[L1D_IDX_W+1:2];
  assign tag = addr_i[ADDR_W-1:L1D_IDX_W+2];

  assign in_win0   = (addr_i >= CACHE_WIN0_LO) && (addr_i < CACHE_WIN0_HI);
  assign in_win1   = (addr_i >= CACHE_WIN1_LO) && (addr_i < CACHE_WIN1_HI);
  assign cacheable = in_win0 || in_win1;

  assign hit_o      = cacheable && valid_q[idx] && (tag_q[idx] == tag);
  assign hit_data_o = data_q[idx];

  // valid bits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      if (fill_en_i && cacheable) begin
        valid_q[idx] <= 1'b1;
      end
      // a store drops the line, no write-through update
      if (inval_en_i && hit_o) begin
        valid_q[idx] <= 1'b0;
      end
    end
  end

  // line payload
  always_ff @(posedge clk) begin
    if (fill_en_i && cacheable) begin
      data_q[idx] <= fill_data_i;
      tag_q[idx]  <= tag;
    end
  end

endmodule

// File: hdl/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
  input  lsu_pkg::mem_op_e           op_i,
  input  logic [1:0]                 addr_lo_i,
  input  logic [lsu_pkg::DATA_W-1:0] word_i,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o
);

  import lsu_pkg::*;

  logic [DATA_W-1:0] shifted;

  // addressed byte down to lane 0
  assign shifted = word_i >> {addr_lo_i, 3'b000};

  always_comb begin
    case (op_i)
      LB: begin
        rdata_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      LBU: begin
        rdata_o = {24'h00_0000, shifted[7:0]};
      end
      LH: begin
        rdata_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      LHU: begin
        rdata_o = {16'h0000, shifted[15:0]};
      end
      default: begin
        // LW, offset is zero for aligned words
        rdata_o = shifted;
      end
    endcase
  end

endmodule

// File: hdl/lsu_strobe_gen.sv
`timescale 1ns/1ps

module lsu_strobe_gen (
  input  lsu_pkg::mem_op_e           op_i,
  input  logic [1:0]                 addr_lo_i,
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
  output logic [lsu_pkg::SEL_W-1:0]  sel_o,
  output logic [lsu_pkg::DATA_W-1:0] wdata_o
);

  import lsu_pkg::*;

  // byte lanes touched by the access
  always_comb begin
    case (op_i)
      LB, LBU, SB: begin
        sel_o = 4'b0001 << addr_lo_i;
      end
      LH, LHU, SH: begin
        // halfword lanes, bit 0 of the offset is ignored
        sel_o = 4'b0011 << {addr_lo_i[1], 1'b0};
      end
      default: begin
        sel_o = 4'b1111;
      end
    endcase
  end

  // copy narrow store data into every lane, sel picks the live ones
  always_comb begin
    case (op_i)
      SB: begin
        wdata_o = {4{wdata_i[7:0]}};
      end
      SH: begin
        wdata_o = {2{wdata_i[15:0]}};
      end
      default: begin
        wdata_o = wdata_i;
      end
    endcase
  end

endmodule

// File: hdl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
  input  logic clk,
  input  logic reset_i,
  // execute side
  input  logic req_valid_i,
  input  logic req_is_store_i,
  // cache lookup result
  input  logic hit_i,
  // wishbone
  input  logic wb_ack_i,
  output logic wb_cyc_o,
  output logic wb_stb_o,
  output logic wb_we_o,
  // cache update strobes
  output logic fill_en_o,
  output logic inval_en_o,
  // completion and read data source
  output logic done_o,
  output logic data_sel_o
);

  import lsu_pkg::*;

  lsu_state_e state_q;
  lsu_state_e state_d;

  // 1 picks the bus word, 0 the cache word
  logic data_sel_q;

  logic in_bus;
  logic bus_end;
  logic load_hit;

  assign in_bus   = (state_q == BUS);
  assign bus_end  = in_bus && wb_ack_i;
  assign load_hit = hit_i && !req_is_store_i;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        // stores always go out, loads only on a miss
        if (load_hit) begin
          state_d = DONE;
        end else begin
          state_d = BUS;
        end
      end
      BUS: begin
        // hold the cycle while the slave stalls
        if (wb_ack_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= IDLE;
      data_sel_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // source of load data is fixed at lookup time
      if (state_q == LOOKUP) begin
        data_sel_q <= !load_hit;
      end
    end
  end

  // cyc and stb follow the bus state, drop the cycle after ack
  assign wb_cyc_o = in_bus;
  assign wb_stb_o = in_bus;
  assign wb_we_o  = in_bus && req_is_store_i;

  // any load ack may fill, the cache filters by window
  assign fill_en_o  = bus_end && !req_is_store_i;
  assign inval_en_o = bus_end && req_is_store_i;

  assign done_o     = (state_q == DONE);
  assign data_sel_o = data_sel_q;

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

  // datapath widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = 4;

  // l1d geometry, one word per line
  localparam int L1D_LINES = 4;
  localparam int L1D_IDX_W = 2;
  // address bits above index and byte offset
  localparam int L1D_TAG_W = ADDR_W - L1D_IDX_W - 2;

  // cacheable windows, upper bounds are exclusive
  localparam logic [ADDR_W-1:0] CACHE_WIN0_LO = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN0_HI = 32'h8040_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN1_LO = 32'hA000_0000;
  localparam logic [ADDR_W-1:0] CACHE_WIN1_HI = 32'hC000_0000;

  // memory opcodes
  // stores have bit 3 set, loads have it clear
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LBU = 4'b0001,
    LH  = 4'b0010,
    LHU = 4'b0011,
    LW  = 4'b0100,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } mem_op_e;

  // access sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    LOOKUP = 2'b01,
    BUS    = 2'b10,
    DONE   = 2'b11
  } lsu_state_e;

  // store group test on the encoding
  function automatic logic is_store_op(input mem_op_e op);
    return op[3];
  endfunction

endpackage
